/* hw/life_pkg.sv */
//////////////////////////////
// Life grid geometry, row types and the row write bundle
// shared by the seed loader, rule pipeline and grid store
//////////////////////////////
package life_pkg;

	//////////////////////////////
	// Grid geometry
	//////////////////////////////

	localparam int GRID_W    = 16;     // Cells per row, one memory word
	localparam int GRID_ROWS = 16;     // Rows in the torus
	localparam int ROW_BITS  = 4;      // Row index width

	// Cycles from pass start to the done pulse
	// 18 row reads plus pipe fill and write out
	localparam int PASS_CYCLES = GRID_ROWS + 4;
	localparam int PASS_BITS   = $clog2(PASS_CYCLES + 1); // Counts 0 to PASS_CYCLES

	//////////////////////////////
	// Row types
	//////////////////////////////

	typedef logic [GRID_W-1:0]    row_t;      // One row of cells, bit n is column n
	typedef logic [ROW_BITS-1:0]  row_addr_t; // Row index in a bank
	typedef logic [PASS_BITS-1:0] pass_cnt_t; // Cycle index inside a pass

	// One row write into the two-bank store
	typedef struct packed {
		logic      en;    // Write strobe
		logic      bank;  // Target bank
		row_addr_t addr;  // Target row
		row_t      data;  // New row contents
	} row_wr_t;

endpackage

/* hw/ctrl_pkg.sv */
//////////////////////////////
// Control constants and host port types
// Button timing, LFSR seed, host read bundles
//////////////////////////////
package ctrl_pkg;

	//////////////////////////////
	// Button timing in clk4 cycles
	//////////////////////////////

	localparam int PRESS_CYCLES   = 8;   // Held this long counts as a press
	localparam int LONG_CYCLES    = 64;  // Held this long enters run mode
	localparam int RELEASE_CYCLES = 16;  // Low this long returns to idle

	localparam int HOLD_BITS = $clog2(LONG_CYCLES + 1);    // Held-time counter width
	localparam int REL_BITS  = $clog2(RELEASE_CYCLES + 1); // Low-time counter width

	// Grid seed, must be non-zero
	localparam logic [31:0] SEED = 32'h1b5e_a7c3;

	//////////////////////////////
	// Host read port
	//////////////////////////////

	typedef struct packed {
		logic                req;   // Held high until ack seen
		life_pkg::row_addr_t addr;  // Stable while req high
	} host_rd_req_t;

	typedef struct packed {
		logic           ack;   // Four phase acknowledge
		life_pkg::row_t data;  // Valid and stable while ack high
	} host_rd_rsp_t;

	typedef logic [31:0] gen_count_t; // Total generations since reset

endpackage

/* hw/button_filter.sv */
//////////////////////////////
// Fire button synchronizer and debounce
// Short press gives a step pulse, long hold gives run
//////////////////////////////
`timescale 1ns/1ns

module button_filter
	import ctrl_pkg::*;
(
	input  logic clk4,
	input  logic reset,
	input  logic fire_button,  // Async, may bounce
	output logic step,         // One pulse per qualified press
	output logic run           // High during a long hold and its release time
);

	typedef enum logic [2:0] {
		ST_IDLE,        // Button up
		ST_WAIT_PRESS,  // Qualifying a press
		ST_WAIT_LONG,   // Pressed, step sent
		ST_LONG,        // Run mode, held
		ST_WAIT_OFF,    // Released after a short press
		ST_WAIT_LOFF    // Released after run mode
	} btn_state_t;

	btn_state_t           state;
	logic [2:0]           sync_q;    // Three stage synchronizer
	logic                 held;      // Synchronized button level
	logic [HOLD_BITS-1:0] hold_cnt;  // Cycles held since leaving idle
	logic [REL_BITS-1:0]  low_cnt;   // Cycles low while releasing

	always_ff @(posedge clk4) begin
		if (reset) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[1:0], fire_button};
		end
	end
	assign held = sync_q[2];

	//////////////////////////////
	// Press state machine
	//////////////////////////////
	always_ff @(posedge clk4) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (held) state <= ST_WAIT_PRESS;
				ST_WAIT_PRESS: begin
					if (!held)
						state <= ST_IDLE;          // Glitch, drop it
					else if (hold_cnt == HOLD_BITS'(PRESS_CYCLES - 1))
						state <= ST_WAIT_LONG;
				end
				ST_WAIT_LONG: begin
					if (!held)
						state <= ST_WAIT_OFF;
					else if (hold_cnt == HOLD_BITS'(LONG_CYCLES - 1))
						state <= ST_LONG;          // Held long enough for run
				end
				ST_LONG: if (!held) state <= ST_WAIT_LOFF;
				ST_WAIT_OFF: begin
					if (held)
						state <= ST_WAIT_LONG;     // Bounce while releasing
					else if (low_cnt == REL_BITS'(RELEASE_CYCLES - 1))
						state <= ST_IDLE;
				end
				ST_WAIT_LOFF: begin
					if (held)
						state <= ST_LONG;
					else if (low_cnt == REL_BITS'(RELEASE_CYCLES - 1))
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Held and released time counters
	always_ff @(posedge clk4) begin
		if (reset) begin
			hold_cnt <= '0;
			low_cnt  <= '0;
			step     <= 1'b0;
		end else begin
			if (state == ST_IDLE)
				hold_cnt <= HOLD_BITS'(held);  // First held cycle counts
			else if (held && (state == ST_WAIT_PRESS || state == ST_WAIT_LONG))
				hold_cnt <= hold_cnt + 1'b1;
			if (!held && state != ST_IDLE && state != ST_WAIT_PRESS)
				low_cnt <= low_cnt + 1'b1;
			else
				low_cnt <= '0;
			step <= (state == ST_WAIT_PRESS) && held &&
				(hold_cnt == HOLD_BITS'(PRESS_CYCLES - 1)); // Once per press
		end
	end

	assign run = (state == ST_LONG) || (state == ST_WAIT_LOFF);

endmodule

/* hw/seed_lfsr.sv */
//////////////////////////////
// Grid seed loader
// Writes 16 LFSR rows into bank 0 after reset
//////////////////////////////
`timescale 1ns/1ns

module seed_lfsr
	import life_pkg::*;
	import ctrl_pkg::*;
(
	input  logic    clk4,
	input  logic    reset,
	output row_wr_t seed_wr,    // One row per cycle while busy
	output logic    seed_busy   // Falls after the last row
);

	logic [31:0] lfsr;     // Fibonacci LFSR state
	row_addr_t   row_cnt;  // Row being written
	logic        fb;

	assign fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32 22 2 1

	always_ff @(posedge clk4) begin
		if (reset) begin
			lfsr      <= SEED;
			row_cnt   <= '0;
			seed_busy <= 1'b1;
		end else if (seed_busy) begin
			lfsr    <= {lfsr[30:0], fb};   // Shift left, feedback in at bit 0
			row_cnt <= row_cnt + 1'b1;
			if (row_cnt == row_addr_t'(GRID_ROWS - 1)) begin
				seed_busy <= 1'b0;         // Done, stay quiet from here
			end
		end
	end

	// Low bits of the current state become the row
	assign seed_wr = '{
		en:   seed_busy,
		bank: 1'b0,
		addr: row_cnt,
		data: lfsr[GRID_W-1:0]
	};

endmodule

/* hw/pass_sequencer.sv */
//////////////////////////////
// Generation pass and host read scheduler
// Owns the current bank, the generation count and the read port
//////////////////////////////
`timescale 1ns/1ns

module pass_sequencer
	import life_pkg::*;
	import ctrl_pkg::*;
(
	input  logic         clk4,
	input  logic         reset,
	input  logic         step,        // Single generation request
	input  logic         run,         // Continuous generations
	input  logic         seed_busy,   // Grid not ready yet
	input  host_rd_req_t host_rd,
	output host_rd_rsp_t host_rsp,
	output row_addr_t    rd_addr,     // Store read address
	output logic         rd_bank,     // Store read bank
	input  row_t         rd_row,      // Store read data, one cycle later
	output logic         pass_start,  // First cycle of a pass
	output gen_count_t   gen_count,
	output logic         gen_done,    // Pass finished
	output logic         bank         // Bank holding the current generation
);

	typedef enum logic [1:0] {
		ST_IDLE,  // Free, host address on the read port
		ST_PASS,  // Streaming rows to the rule pipe
		ST_HOST   // Host handshake in progress
	} seq_state_t;

	seq_state_t state;
	pass_cnt_t  pcnt;        // Cycle inside the pass
	logic       step_pend;   // Step seen, pass not yet started
	logic       start_pass;
	logic       take_host;
	logic       ack_q;
	row_t       host_data;   // Row returned to the host

	// Host first so a run loop cannot starve it
	assign take_host  = (state == ST_IDLE) && !seed_busy && host_rd.req;
	assign start_pass = (state == ST_IDLE) && !seed_busy && !host_rd.req &&
		(step_pend || run);

	//////////////////////////////
	// Control FSM
	//////////////////////////////
	always_ff @(posedge clk4) begin
		if (reset) begin
			state     <= ST_IDLE;
			pcnt      <= '0;
			step_pend <= 1'b0;
			bank      <= 1'b0;
			gen_count <= '0;
			gen_done  <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			step_pend <= step || (step_pend && !start_pass); // Hold a step until served
			gen_done  <= 1'b0;
			case (state)
				ST_IDLE: begin
					pcnt <= '0;
					if (take_host)
						state <= ST_HOST;
					else if (start_pass)
						state <= ST_PASS;
				end
				ST_PASS: begin
					pcnt <= pcnt + 1'b1;
					if (pcnt == pass_cnt_t'(PASS_CYCLES - 1)) begin
						gen_done  <= 1'b1;
						gen_count <= gen_count + 32'd1;
						bank      <= !bank;        // New generation now current
					end
					// One extra cycle lets the last row land before any read
					if (pcnt == pass_cnt_t'(PASS_CYCLES))
						state <= ST_IDLE;
				end
				ST_HOST: begin
					if (!ack_q) begin
						ack_q <= 1'b1;             // Row already read last cycle
					end else if (!host_rd.req) begin
						ack_q <= 1'b0;             // Drop one cycle after req
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Capture the row once, held while ack is high
	always_ff @(posedge clk4) begin
		if (state == ST_HOST && !ack_q) begin
			host_data <= rd_row;
		end
	end

	// Pass reads row 15, rows 0 to 15, then row 0 again
	assign rd_addr = (state == ST_PASS) ? pcnt[ROW_BITS-1:0] - row_addr_t'(1) : host_rd.addr;
	assign rd_bank = bank;

	assign pass_start = (state == ST_PASS) && (pcnt == '0);
	assign host_rsp   = '{ack: ack_q, data: host_data};

endmodule

/* hw/life_rule_pipe.sv */
//////////////////////////////
// Life rule row pipeline
// Three row window in, next generation rows out to the other bank
//////////////////////////////
`timescale 1ns/1ns

module life_rule_pipe
	import life_pkg::*;
(
	input  logic    clk4,
	input  logic    reset,
	input  logic    pass_start,  // Row 15 read issued this cycle
	input  logic    bank,        // Bank being read
	input  row_t    rd_row,      // Row stream from the store
	output row_wr_t rule_wr      // Next generation row writes
);

	pass_cnt_t cnt;        // Cycles since pass_start, zero when idle
	logic      shift_en;   // rd_row carries pass data
	row_t      win_top;    // Row above
	row_t      win_mid;    // Row being computed
	row_t      win_bot;    // Row below
	logic      wr_en;
	logic      wr_bank;
	row_addr_t wr_addr;
	row_t      wr_data;

	// Next state of one row from its neighbours, wraps at the column edges
	function automatic row_t next_row(input row_t up, input row_t mid, input row_t dn);
		row_t       nxt;
		logic [3:0] n;    // Live neighbour count
		int         l;
		int         r;
		for (int c = 0; c < GRID_W; c++) begin
			l = (c + GRID_W - 1) % GRID_W;
			r = (c + 1) % GRID_W;
			n = 4'(up[l]) + 4'(up[c]) + 4'(up[r]) +
				4'(mid[l]) + 4'(mid[r]) +
				4'(dn[l]) + 4'(dn[c]) + 4'(dn[r]);
			nxt[c] = (n == 4'd3) || (mid[c] && n == 4'd2); // Birth or survival
		end
		return nxt;
	endfunction

	// 18 rows arrive in cycles 1 to 18
	assign shift_en = (cnt != '0) && (cnt <= pass_cnt_t'(GRID_ROWS + 2));

	always_ff @(posedge clk4) begin
		if (reset) begin
			cnt   <= '0;
			wr_en <= 1'b0;
		end else begin
			if (pass_start)
				cnt <= pass_cnt_t'(1);
			else if (cnt == pass_cnt_t'(PASS_CYCLES - 1))
				cnt <= '0;                      // Last row computed
			else if (cnt != '0)
				cnt <= cnt + 1'b1;
			// Window full from cycle 4 to 19
			wr_en <= (cnt >= pass_cnt_t'(PASS_CYCLES - GRID_ROWS)) &&
				(cnt <= pass_cnt_t'(PASS_CYCLES - 1));
		end
	end

	//////////////////////////////
	// Window and result registers
	//////////////////////////////
	always_ff @(posedge clk4) begin
		if (shift_en) begin
			win_top <= win_mid;
			win_mid <= win_bot;
			win_bot <= rd_row;
		end
		wr_data <= next_row(win_top, win_mid, win_bot);
		wr_addr <= cnt[ROW_BITS-1:0] - row_addr_t'(PASS_CYCLES - GRID_ROWS); // Middle row index
		wr_bank <= !bank;                      // Write the idle bank
	end

	assign rule_wr = '{en: wr_en, bank: wr_bank, addr: wr_addr, data: wr_data};

endmodule

/* hw/grid_store.sv */
//////////////////////////////
// Two bank grid row memory
// Seed and rule writes merged, one registered read port
//////////////////////////////
`timescale 1ns/1ns

module grid_store
	import life_pkg::*;
(
	input  logic      clk4,
	input  row_wr_t   seed_wr,  // Seed loader writes
	input  row_wr_t   rule_wr,  // Rule pipeline writes
	input  row_addr_t rd_addr,
	input  logic      rd_bank,
	output row_t      rd_row    // Data for last cycle's address
);

	row_t    mem [2][GRID_ROWS];  // Bank, row
	row_wr_t wr;                  // Selected write

	// Seed has priority, the two never overlap in use
	always_comb begin
		wr = seed_wr.en ? seed_wr : rule_wr;
	end

	always_ff @(posedge clk4) begin
		if (wr.en) begin
			mem[wr.bank][wr.addr] <= wr.data;
		end
		rd_row <= mem[rd_bank][rd_addr];  // Read before write on a collision
	end

endmodule

/* hw/life_top.sv */
//////////////////////////////
// Game of Life engine top level
// Button, sequencer, seed and rule writers around the grid store
//////////////////////////////
`timescale 1ns/1ns

module life_top
	import life_pkg::*;
	import ctrl_pkg::*;
(
	input  logic         clk4,
	input  logic         reset,
	input  logic         fire_button,  // Raw push button
	input  host_rd_req_t host_rd,      // Host row read request
	output host_rd_rsp_t host_rsp,     // Host row read response
	output gen_count_t   gen_count,    // Total generations
	output logic         gen_done,     // One pulse per finished pass
	output logic         seed_busy     // High while the grid is seeded
);

	logic      step;       // Short press pulse
	logic      run;        // Long hold level
	row_wr_t   seed_wr;    // Seed loader writes
	row_wr_t   rule_wr;    // Next generation writes
	row_addr_t rd_addr;
	logic      rd_bank;
	row_t      rd_row;     // Store read data, one cycle after address
	logic      pass_start;
	logic      bank;       // Bank holding the current generation

	// Fire button to step and run
	button_filter i_button_filter (
		.clk4        (clk4),
		.reset       (reset),
		.fire_button (fire_button),
		.step        (step),
		.run         (run)
	);

	// Initial pattern
	seed_lfsr i_seed_lfsr (
		.clk4      (clk4),
		.reset     (reset),
		.seed_wr   (seed_wr),
		.seed_busy (seed_busy)
	);

	// Pass and host read scheduling
	pass_sequencer i_pass_sequencer (
		.clk4       (clk4),
		.reset      (reset),
		.step       (step),
		.run        (run),
		.seed_busy  (seed_busy),
		.host_rd    (host_rd),
		.host_rsp   (host_rsp),
		.rd_addr    (rd_addr),
		.rd_bank    (rd_bank),
		.rd_row     (rd_row),
		.pass_start (pass_start),
		.gen_count  (gen_count),
		.gen_done   (gen_done),
		.bank       (bank)
	);

	// Life rule on a three row window
	life_rule_pipe i_life_rule_pipe (
		.clk4       (clk4),
		.reset      (reset),
		.pass_start (pass_start),
		.bank       (bank),
		.rd_row     (rd_row),
		.rule_wr    (rule_wr)
	);

	// Two bank row memory
	grid_store i_grid_store (
		.clk4    (clk4),
		.seed_wr (seed_wr),
		.rule_wr (rule_wr),
		.rd_addr (rd_addr),
		.rd_bank (rd_bank),
		.rd_row  (rd_row)
	);

endmodule

/* include/life_model.svh */
//////////////////////////////
// Life reference model
// LFSR seed grid and next generation of a 16 row torus
//////////////////////////////
`ifndef LIFE_MODEL_SVH
`define LIFE_MODEL_SVH

typedef life_pkg::row_t model_grid_t [life_pkg::GRID_ROWS];

// One LFSR step with taps 32 22 2 1 shifting left
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Rows as written by the seed loader
function automatic model_grid_t seed_grid();
	model_grid_t g;
	logic [31:0] s;
	s = ctrl_pkg::SEED;
	for (int r = 0; r < life_pkg::GRID_ROWS; r++) begin
		g[r] = s[life_pkg::GRID_W-1:0];
		s = lfsr_step(s);
	end
	return g;
endfunction

// One generation with wraparound on rows and columns
function automatic model_grid_t next_generation(input model_grid_t g);
	model_grid_t nxt;
	int          n;
	int          rr;
	int          cc;
	for (int r = 0; r < life_pkg::GRID_ROWS; r++) begin
		for (int c = 0; c < life_pkg::GRID_W; c++) begin
			n = 0;
			for (int dr = -1; dr <= 1; dr++) begin
				for (int dc = -1; dc <= 1; dc++) begin
					rr = (r + dr + life_pkg::GRID_ROWS) % life_pkg::GRID_ROWS;
					cc = (c + dc + life_pkg::GRID_W) % life_pkg::GRID_W;
					if ((dr != 0 || dc != 0) && g[rr][cc])
						n++;
				end
			end
			nxt[r][c] = (n == 3) || (g[r][c] && n == 2); // Birth or survival
		end
	end
	return nxt;
endfunction

`endif

/* sim/life_tb.sv */
//////////////////////////////
// Game of Life engine testbench
// Button table and host row reads against the model
//////////////////////////////
`timescale 1ns/1ns

module life_tb
	import life_pkg::*;
	import ctrl_pkg::*;
();

	`include "life_model.svh"

	localparam int NUM_STIM     = 7;
	localparam int RUN_READS    = 6;                  // Host reads while run is high
	localparam int QUIET_CYCLES = 2 * PASS_CYCLES + 8; // No gen_count change this long
	localparam int READ_CYCLES  = PASS_CYCLES + 8;     // Worst host read incl. back-pressure
	localparam int BOUNCE_MAX   = 11;                 // Longest glitch plus its gap

	// One table entry
	typedef struct packed {
		int press;      // Held cycles or 0 for none
		int bounces;    // Glitches before the press
		int exp_delta;  // gen_count rise or -1 for run mode
		int reads;      // Number of rows read back
	} stim_t;

	logic         clk4;
	logic         reset;
	logic         fire_button;
	host_rd_req_t host_rd;
	host_rd_rsp_t host_rsp;
	gen_count_t   gen_count;
	logic         gen_done;
	logic         seed_busy;

	stim_t       stim [NUM_STIM];
	model_grid_t model_grid;    // Model at model_gen
	gen_count_t  model_gen;
	logic [31:0] lcg_state;
	int          cycles;
	int          cycle_limit;

	life_top i_life_top (
		.clk4        (clk4),
		.reset       (reset),
		.fire_button (fire_button),
		.host_rd     (host_rd),
		.host_rsp    (host_rsp),
		.gen_count   (gen_count),
		.gen_done    (gen_done),
		.seed_busy   (seed_busy)
	);

	initial begin
		clk4 = 1'b0;
		forever #2 clk4 = ~clk4;  // 4 ns period
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic stim_t make_stim(input int press, input int bounces,
		input int exp_delta, input int reads);
		stim_t s;
		s.press     = press;
		s.bounces   = bounces;
		s.exp_delta = exp_delta;
		s.reads     = reads;
		return s;
	endfunction

	// Model grid after gen generations starting from the stored model
	function automatic model_grid_t grid_at(input gen_count_t gen);
		model_grid_t g;
		g = model_grid;
		for (gen_count_t k = model_gen; k < gen; k++)
			g = next_generation(g);
		return g;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Step to 1 ns after the next edge where outputs are settled
	task automatic wait_cycle();
		@(posedge clk4);
		#1;
	endtask

	// Four phase read of one row returning data and gen_count at ack
	task automatic host_read(input row_addr_t addr, output row_t data, output gen_count_t gen);
		check_value(host_rsp.ack, 1'b0, "ack high before req");
		host_rd.addr = addr;
		host_rd.req  = 1'b1;
		wait_cycle();
		while (!host_rsp.ack)
			wait_cycle();                           // Back-pressure from pass or seed
		data = host_rsp.data;
		gen  = gen_count;
		wait_cycle();
		check_value(host_rsp.ack, 1'b1, "ack dropped while req high");
		check_value(host_rsp.data, data, "data moved while ack high");
		host_rd.req = 1'b0;
		wait_cycle();
		check_value(host_rsp.ack, 1'b0, "ack not dropped one cycle after req");
	endtask

	// Short glitches below the press time
	task automatic apply_bounces(input int n);
		for (int b = 0; b < n; b++) begin
			fire_button = 1'b1;
			repeat (1 + lcg_next() % 5) wait_cycle();
			fire_button = 1'b0;
			repeat (3 + lcg_next() % 4) wait_cycle();
		end
	endtask

	// Reads while the run loop keeps going
	task automatic run_reads();
		row_t       data;
		gen_count_t gen;
		model_grid_t g;
		row_addr_t  addr;
		for (int k = 0; k < RUN_READS; k++) begin
			addr = row_addr_t'(lcg_next() % GRID_ROWS);
			host_read(addr, data, gen);
			g = grid_at(gen);
			check_value(data, g[addr], "run mode row");
			repeat (lcg_next() % 24) wait_cycle();  // Let passes through
		end
	endtask

	// Wait until gen_count has settled
	task automatic wait_quiet();
		gen_count_t last;
		int         quiet;
		last  = gen_count;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			wait_cycle();
			check_value(gen_done, gen_count != last, "gen_done against gen_count change");
			if (gen_count != last) begin
				check_value(gen_count, last + 32'd1, "gen_count step size");
				last  = gen_count;
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	task automatic read_rows(input int n);
		row_t       data;
		gen_count_t gen;
		row_addr_t  addr;
		for (int k = 0; k < n; k++) begin
			addr = (n == GRID_ROWS) ? row_addr_t'(k) : row_addr_t'(lcg_next() % GRID_ROWS);
			host_read(addr, data, gen);
			check_value(gen, model_gen, "gen_count at idle read");
			check_value(data, model_grid[addr], "grid row");
		end
	endtask

	//////////////////////////////
	// Timeout
	//////////////////////////////
	always @(posedge clk4) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		gen_count_t start_gen;
		gen_count_t delta;
		int         seed_cycles;
		cycles       = 0;
		lcg_state    = 32'hcfd449ab;
		reset        = 1'b1;
		fire_button  = 1'b0;
		host_rd      = '0;

		stim[0] = make_stim(0,   0, 0,  16);  // Seed rows
		stim[1] = make_stim(20,  0, 1,  16);  // Single step
		stim[2] = make_stim(5,   0, 0,  16);  // Too short
		stim[3] = make_stim(0,   4, 0,  16);  // Glitches only
		stim[4] = make_stim(30,  3, 1,  16);  // Bounce then step
		stim[5] = make_stim(200, 0, -1, 16);  // Run mode
		stim[6] = make_stim(12,  2, 1,  8);

		cycle_limit = 2000 + 3 + GRID_ROWS;
		for (int i = 0; i < NUM_STIM; i++) begin
			cycle_limit += stim[i].press + stim[i].bounces * BOUNCE_MAX + RELEASE_CYCLES +
				QUIET_CYCLES + stim[i].reads * READ_CYCLES;
			if (stim[i].exp_delta < 0)
				cycle_limit += RUN_READS * (READ_CYCLES + 24);
		end

		repeat (3) @(posedge clk4);
		#1;
		reset = 1'b0;
		check_value(gen_count, 32'd0, "gen_count after reset");
		check_value(host_rsp.ack, 1'b0, "ack after reset");
		check_value(gen_done, 1'b0, "gen_done after reset");
		check_value(seed_busy, 1'b1, "seed_busy after reset");
		seed_cycles = 0;
		while (seed_busy) begin
			wait_cycle();
			seed_cycles++;
		end
		check_value(seed_cycles, GRID_ROWS, "seed_busy length");
		model_grid = seed_grid();
		model_gen  = '0;

		for (int i = 0; i < NUM_STIM; i++) begin
			start_gen = gen_count;
			apply_bounces(stim[i].bounces);
			if (stim[i].press > 0) begin
				fire_button = 1'b1;
				repeat (stim[i].press) wait_cycle();
				if (stim[i].exp_delta < 0)
					run_reads();                // Button still held
				fire_button = 1'b0;
			end
			wait_quiet();
			delta = gen_count - start_gen;
			if (stim[i].exp_delta < 0)
				check_value(delta >= 2, 1'b1, "run mode gave repeated passes");
			else
				check_value(delta, stim[i].exp_delta, "gen_count delta");
			model_grid = grid_at(gen_count);
			model_gen  = gen_count;
			read_rows(stim[i].reads);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* life_top.f */
+incdir+include
hw/life_pkg.sv
hw/ctrl_pkg.sv
hw/button_filter.sv
hw/seed_lfsr.sv
hw/pass_sequencer.sv
hw/life_rule_pipe.sv
hw/grid_store.sv
hw/life_top.sv
sim/life_tb.sv

/* Bender.yml */
package:
  name: life_top

sources:
  - files:
      - hw/life_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/button_filter.sv
      - hw/seed_lfsr.sv
      - hw/pass_sequencer.sv
      - hw/life_rule_pipe.sv
      - hw/grid_store.sv
      - hw/life_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/life_tb.sv
